//--- hdl/frame_pkg.sv
`default_nettype none

package frame_pkg;

    //////////////////////////////
    // frame geometry.
    //////////////////////////////
    localparam int num_columns = 16;
    localparam int num_rows = 8;
    localparam int bytes_per_pixel = 2;

    // entries in the write queue.
    localparam int queue_depth = 4;

    //////////////////////////////
    // coordinate and data types.
    //////////////////////////////
    typedef logic [3:0] column_t;
    typedef logic [2:0] row_t;

    // byte index within one pixel.
    typedef logic [0:0] pixel_sel_t;

    // byte k of a color sits at bits 8k+7 down to 8k.
    typedef logic [15:0] color_t;
    typedef logic [7:0] byte_t;

    // row, then column, then pixel byte, msb first.
    typedef logic [7:0] frame_addr_t;

endpackage

`default_nettype wire

//--- hdl/fill_cmd_pkg.sv
`default_nettype none

package fill_cmd_pkg;

    // opcode of the fill command, the only one accepted.
    localparam logic [7:0] op_fill = 8'h01;

    // opcode, x1, y1, width, height, color high, color low.
    localparam int cmd_len = 7;

    typedef enum logic [1:0] {
        idle,
        collect,
        run,
        finish
    } parser_state_t;

    typedef enum logic [1:0] {
        prime,
        write,
        wait_ack
    } fill_state_t;

endpackage

`default_nettype wire

//--- hdl/fill_cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

module fill_cmd_parser
    import frame_pkg::*;
    import fill_cmd_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire byte_t cmd_byte,
    input  wire        cmd_valid,
    input  wire        queue_almost_full,
    input  wire        queue_empty,
    input  wire        writer_idle,
    input  wire        done,
    output column_t    x1,
    output row_t       y1,
    output column_t    width,
    output row_t       height,
    output color_t     color,
    output logic       fill_enable,
    output logic       ack,
    output logic       busy,
    output logic       cmd_reject
);
    parser_state_t state;
    logic [2:0] byte_count;
    logic last_byte;

    // fields kept as full bytes so the range check sees the raw values.
    byte_t x1_q;
    byte_t y1_q;
    byte_t width_q;
    byte_t height_q;
    color_t color_q;

    logic [8:0] x_end;
    logic [8:0] y_end;
    logic area_ok;

    assign x_end = {1'b0, x1_q} + {1'b0, width_q};
    assign y_end = {1'b0, y1_q} + {1'b0, height_q};
    assign area_ok = (width_q != '0) && (height_q != '0) &&
                     (x_end <= 9'(num_columns)) && (y_end <= 9'(num_rows));

    assign last_byte = cmd_valid && (state == collect) && (byte_count == 3'(cmd_len - 1));

    assign busy = (state == run) || (state == finish);
    assign fill_enable = (state == run) && !queue_almost_full;
    // release the engine only once every byte has reached memory.
    assign ack = (state == finish) && done && queue_empty && writer_idle;

    // full 16x8 frame wraps to zero here; the engine works modulo the width.
    assign x1 = x1_q[$bits(column_t)-1:0];
    assign y1 = y1_q[$bits(row_t)-1:0];
    assign width = width_q[$bits(column_t)-1:0];
    assign height = height_q[$bits(row_t)-1:0];
    assign color = color_q;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= idle;
            byte_count <= '0;
            cmd_reject <= 1'b0;
        end else begin
            cmd_reject <= busy && cmd_valid;
            case (state)
                idle: begin
                    if (cmd_valid) begin
                        if (cmd_byte == op_fill) begin
                            state <= collect;
                            byte_count <= 3'd1;
                        end else begin
                            cmd_reject <= 1'b1;
                        end
                    end
                end
                collect: begin
                    if (cmd_valid) begin
                        byte_count <= byte_count + 3'd1;
                    end
                    if (last_byte) begin
                        if (area_ok) begin
                            state <= run;
                        end else begin
                            state <= idle;
                            cmd_reject <= 1'b1;
                        end
                    end
                end
                run: begin
                    if (done) begin
                        state <= finish;
                    end
                end
                finish: begin
                    if (ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // field capture.
    always_ff @(posedge clk) begin
        if (cmd_valid && (state == collect)) begin
            case (byte_count)
                3'd1: x1_q <= cmd_byte;
                3'd2: y1_q <= cmd_byte;
                3'd3: width_q <= cmd_byte;
                3'd4: height_q <= cmd_byte;
                3'd5: color_q[15:8] <= cmd_byte;
                3'd6: color_q[7:0] <= cmd_byte;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fill_area_engine.sv
`timescale 1ns/100ps
`default_nettype none

module fill_area_engine
    import frame_pkg::*;
    import fill_cmd_pkg::*;
(
    input  wire          clk,
    input  wire          reset,
    input  wire          enable,
    input  wire          ack,
    input  wire column_t x1,
    input  wire row_t    y1,
    input  wire column_t width,
    input  wire row_t    height,
    input  wire color_t  color,
    output row_t         wr_row,
    output column_t      wr_column,
    output pixel_sel_t   wr_pixel,
    output byte_t        wr_data,
    output logic         wr_valid,
    output logic         done
);
    /* walk order

         (x1,y1)
            .---------.
            | <-- <-- |
            | <-- <-- |
            '---------.
                      ^ start, (x_last, y_last)

       each pixel goes from its top byte down to byte 0.
    */

    fill_state_t state;
    column_t x_last;
    row_t y_last;
    pixel_sel_t top_pixel;
    logic last_step;

    // modular sums, so a full-width area still lands on the right edge.
    assign x_last = column_t'(x1 + width - 1'b1);
    assign y_last = row_t'(y1 + height - 1'b1);
    assign top_pixel = pixel_sel_t'(bytes_per_pixel - 1);

    assign last_step = (wr_row == y1) && (wr_column == x1) && (wr_pixel == '0);

    assign wr_valid = enable && (state == write);
    assign wr_data = color[wr_pixel*8 +: 8];

    //////////////////////////////
    // control.
    //////////////////////////////
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state <= prime;
            done <= 1'b0;
        end else begin
            case (state)
                prime: begin
                    if (enable) begin
                        state <= write;
                    end
                end
                write: begin
                    if (enable && last_step) begin
                        state <= wait_ack;
                        done <= 1'b1;
                    end
                end
                wait_ack: begin
                    if (ack) begin
                        state <= prime;
                        done <= 1'b0;
                    end
                end
                default: state <= prime;
            endcase
        end
    end

    //////////////////////////////
    // address walk.
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (enable) begin
            if (state == prime) begin
                wr_row <= y_last;
                wr_column <= x_last;
                wr_pixel <= top_pixel;
            end else if ((state == write) && !last_step) begin
                if (wr_pixel == '0) begin
                    wr_pixel <= top_pixel;
                    // wrap to the right edge and move up one row.
                    if (wr_column == x1) begin
                        wr_column <= x_last;
                        wr_row <= wr_row - 1'b1;
                    end else begin
                        wr_column <= wr_column - 1'b1;
                    end
                end else begin
                    wr_pixel <= wr_pixel - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/write_queue.sv
`timescale 1ns/100ps
`default_nettype none

module write_queue
    import frame_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             push,
    input  wire row_t       in_row,
    input  wire column_t    in_column,
    input  wire pixel_sel_t in_pixel,
    input  wire byte_t      in_data,
    input  wire             pop,
    output row_t            q_row,
    output column_t         q_column,
    output pixel_sel_t      q_pixel,
    output byte_t           q_data,
    output logic            queue_almost_full,
    output logic            queue_empty
);
    row_t row_mem [queue_depth];
    column_t column_mem [queue_depth];
    pixel_sel_t pixel_mem [queue_depth];
    byte_t data_mem [queue_depth];

    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    logic [$clog2(queue_depth):0] count;

    // two free slots left is enough to stop the engine in time.
    assign queue_almost_full = (count >= ($clog2(queue_depth) + 1)'(queue_depth - 2));
    assign queue_empty = (count == '0);

    assign q_row = row_mem[rd_ptr];
    assign q_column = column_mem[rd_ptr];
    assign q_pixel = pixel_mem[rd_ptr];
    assign q_data = data_mem[rd_ptr];

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry storage.
    always_ff @(posedge clk) begin
        if (push) begin
            row_mem[wr_ptr] <= in_row;
            column_mem[wr_ptr] <= in_column;
            pixel_mem[wr_ptr] <= in_pixel;
            data_mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_writer.sv
`timescale 1ns/100ps
`default_nettype none

module frame_writer
    import frame_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              queue_empty,
    input  wire row_t        q_row,
    input  wire column_t     q_column,
    input  wire pixel_sel_t  q_pixel,
    input  wire byte_t       q_data,
    output logic             pop,
    output logic             idle,
    input  wire frame_addr_t rd_addr,
    output byte_t            rd_data
);
    byte_t frame_mem [2**$bits(frame_addr_t)];

    // high while a popped entry waits for its write cycle.
    logic pending;
    frame_addr_t write_addr;
    byte_t write_data;

    assign idle = !pending;
    assign pop = !pending && !queue_empty;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= pop;
        end
    end

    // latch the head entry on pop.
    always_ff @(posedge clk) begin
        if (pop) begin
            write_addr <= frame_addr_t'({q_row, q_column, q_pixel});
            write_data <= q_data;
        end
    end

    //////////////////////////////
    // memory and read port.
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (pending) begin
            frame_mem[write_addr] <= write_data;
        end
        rd_data <= frame_mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/fill_subsystem_top.sv
`timescale 1ns/100ps
`default_nettype none

module fill_subsystem_top
    import frame_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire byte_t       cmd_byte,
    input  wire              cmd_valid,
    input  wire frame_addr_t rd_addr,
    output byte_t            rd_data,
    output logic             busy,
    output logic             cmd_reject
);
    // parser to engine.
    column_t fill_x1;
    row_t fill_y1;
    column_t fill_width;
    row_t fill_height;
    color_t fill_color;
    logic fill_enable;
    logic fill_ack;
    logic fill_done;

    // engine to queue.
    row_t wr_row;
    column_t wr_column;
    pixel_sel_t wr_pixel;
    byte_t wr_data;
    logic wr_valid;

    // queue to writer.
    row_t q_row;
    column_t q_column;
    pixel_sel_t q_pixel;
    byte_t q_data;
    logic pop;
    logic queue_almost_full;
    logic queue_empty;
    logic writer_idle;

    fill_cmd_parser parser_i (
        .clk(clk), .reset(reset), .cmd_byte(cmd_byte), .cmd_valid(cmd_valid),
        .queue_almost_full(queue_almost_full), .queue_empty(queue_empty),
        .writer_idle(writer_idle), .done(fill_done),
        .x1(fill_x1), .y1(fill_y1), .width(fill_width), .height(fill_height),
        .color(fill_color), .fill_enable(fill_enable), .ack(fill_ack),
        .busy(busy), .cmd_reject(cmd_reject)
    );

    fill_area_engine engine_i (
        .clk(clk), .reset(reset), .enable(fill_enable), .ack(fill_ack),
        .x1(fill_x1), .y1(fill_y1), .width(fill_width), .height(fill_height),
        .color(fill_color), .wr_row(wr_row), .wr_column(wr_column),
        .wr_pixel(wr_pixel), .wr_data(wr_data), .wr_valid(wr_valid), .done(fill_done)
    );

    write_queue queue_i (
        .clk(clk), .reset(reset), .push(wr_valid), .in_row(wr_row),
        .in_column(wr_column), .in_pixel(wr_pixel), .in_data(wr_data), .pop(pop),
        .q_row(q_row), .q_column(q_column), .q_pixel(q_pixel), .q_data(q_data),
        .queue_almost_full(queue_almost_full), .queue_empty(queue_empty)
    );

    frame_writer writer_i (
        .clk(clk), .reset(reset), .queue_empty(queue_empty), .q_row(q_row),
        .q_column(q_column), .q_pixel(q_pixel), .q_data(q_data), .pop(pop),
        .idle(writer_idle), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

//--- tests/tb_fill_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fill_subsystem
    import frame_pkg::*;
    import fill_cmd_pkg::*;
();
    localparam int num_fixed = 10;
    localparam int num_random = 4;
    localparam int num_tests = num_fixed + num_random;
    localparam int frame_bytes = 2**$bits(frame_addr_t);

    typedef struct packed {
        byte_t  opcode;
        byte_t  x1;
        byte_t  y1;
        byte_t  width;
        byte_t  height;
        color_t color;
        logic   expect_reject;
        logic   poke_busy;
    } test_row_t;

    logic clk;
    logic reset;
    byte_t cmd_byte;
    logic cmd_valid;
    frame_addr_t rd_addr;
    byte_t rd_data;
    logic busy;
    logic cmd_reject;

    test_row_t tests [num_tests];
    byte_t model [frame_bytes];
    int reject_count;
    int test_errors;
    int pass_count;
    int fail_count;
    logic timed_out;

    fill_subsystem_top dut_i (
        .clk(clk), .reset(reset), .cmd_byte(cmd_byte), .cmd_valid(cmd_valid),
        .rd_addr(rd_addr), .rd_data(rd_data), .busy(busy), .cmd_reject(cmd_reject)
    );

    always #20 clk = ~clk;

    // reject pulses, counted away from the driving edge.
    initial reject_count = 0;
    always @(negedge clk) begin
        if (cmd_reject) begin
            reject_count = reject_count + 1;
        end
    end

    //////////////////////////////
    // checks.
    //////////////////////////////
    task automatic check_byte(input frame_addr_t addr, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: frame byte %02h read %02h, expected %02h",
                     $time, addr, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
            test_errors++;
        end
    endtask

    function automatic test_row_t make_row(input byte_t op, input byte_t x, input byte_t y,
                                           input byte_t w, input byte_t h, input color_t c,
                                           input logic rej, input logic poke);
        test_row_t row;
        row.opcode = op;
        row.x1 = x;
        row.y1 = y;
        row.width = w;
        row.height = h;
        row.color = c;
        row.expect_reject = rej;
        row.poke_busy = poke;
        return row;
    endfunction

    task automatic build_table();
        int x;
        int y;
        int w;
        int h;
        tests[0] = make_row(op_fill, 8'd0, 8'd0, 8'd16, 8'd8, 16'h1234, 1'b0, 1'b0);
        tests[1] = make_row(op_fill, 8'd5, 8'd3, 8'd1, 8'd1, 16'hbeef, 1'b0, 1'b0);
        // two overlapping rectangles.
        tests[2] = make_row(op_fill, 8'd2, 8'd1, 8'd6, 8'd4, 16'h0f0f, 1'b0, 1'b0);
        tests[3] = make_row(op_fill, 8'd5, 8'd3, 8'd7, 8'd5, 16'hf00d, 1'b0, 1'b0);
        // no byte here equals the fill opcode.
        tests[4] = make_row(8'h5a, 8'd2, 8'd3, 8'd4, 8'd2, 16'ha5c3, 1'b1, 1'b0);
        tests[5] = make_row(op_fill, 8'd3, 8'd2, 8'd0, 8'd3, 16'h5555, 1'b1, 1'b0);
        tests[6] = make_row(op_fill, 8'd3, 8'd2, 8'd4, 8'd0, 16'h5555, 1'b1, 1'b0);
        tests[7] = make_row(op_fill, 8'd12, 8'd2, 8'd5, 8'd2, 16'h6666, 1'b1, 1'b0);
        tests[8] = make_row(op_fill, 8'd1, 8'd6, 8'd3, 8'd3, 16'h7777, 1'b1, 1'b0);
        tests[9] = make_row(op_fill, 8'd0, 8'd0, 8'd10, 8'd6, 16'h7e81, 1'b0, 1'b1);
        for (int i = 0; i < num_random; i++) begin
            x = int'($urandom % num_columns);
            y = int'($urandom % num_rows);
            w = 1 + int'($urandom % (num_columns - x));
            h = 1 + int'($urandom % (num_rows - y));
            tests[num_fixed + i] = make_row(op_fill, byte_t'(x), byte_t'(y), byte_t'(w),
                                            byte_t'(h), color_t'($urandom), 1'b0, 1'b0);
        end
    endtask

    //////////////////////////////
    // stimulus and waits.
    //////////////////////////////
    task automatic send_byte(input byte_t b);
        cmd_byte = b;
        cmd_valid = 1'b1;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    // color goes high byte first.
    task automatic send_command(input test_row_t row);
        byte_t bytes [cmd_len];
        bytes[0] = row.opcode;
        bytes[1] = row.x1;
        bytes[2] = row.y1;
        bytes[3] = row.width;
        bytes[4] = row.height;
        bytes[5] = row.color[15:8];
        bytes[6] = row.color[7:0];
        for (int i = 0; i < cmd_len; i++) begin
            cmd_byte = bytes[i];
            cmd_valid = 1'b1;
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        ok = (busy === level);
        if (!ok) begin
            $display("timeout: busy did not go %s within %0d cycles",
                     level ? "high" : "low", limit);
        end
    endtask

    task automatic wait_reject(input int base, output logic ok);
        int n;
        n = 0;
        while (reject_count == base && n < 10) begin
            @(posedge clk);
            #2;
            n++;
        end
        ok = (reject_count != base);
        if (!ok) begin
            $display("timeout: no cmd_reject pulse within 10 cycles");
        end
    endtask

    // every byte of the rectangle gets byte k of the color.
    task automatic apply_fill(input test_row_t row);
        frame_addr_t addr;
        for (int r = int'(row.y1); r < int'(row.y1) + int'(row.height); r++) begin
            for (int c = int'(row.x1); c < int'(row.x1) + int'(row.width); c++) begin
                for (int k = 0; k < bytes_per_pixel; k++) begin
                    addr = frame_addr_t'((r * num_columns + c) * bytes_per_pixel + k);
                    model[addr] = row.color[8*k +: 8];
                end
            end
        end
    endtask

    task automatic sweep_frame();
        frame_addr_t addr;
        for (int a = 0; a < frame_bytes; a++) begin
            addr = frame_addr_t'(a);
            rd_addr = addr;
            @(posedge clk);
            #2;
            check_byte(addr, rd_data, model[addr]);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic run_test(input int t);
        test_row_t row;
        int base;
        logic ok;
        row = tests[t];
        test_errors = 0;
        base = reject_count;
        send_command(row);
        if (row.expect_reject) begin
            wait_reject(base, ok);
            if (ok) begin
                repeat (4) @(posedge clk);
                #2;
                check_flag("busy after reject", busy, 1'b0);
            end
        end else begin
            wait_busy(1'b1, 20, ok);
            if (ok && row.poke_busy) begin
                send_byte(op_fill);
                wait_reject(base, ok);
            end
            if (ok) begin
                wait_busy(1'b0, 2000, ok);
            end
            if (ok) begin
                apply_fill(row);
                check_flag("cmd_reject seen", reject_count != base, row.poke_busy);
            end
        end
        if (ok) begin
            sweep_frame();
        end else begin
            timed_out = 1'b1;
        end
        if (ok && test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d: opcode %02h %0dx%0d at (%0d,%0d) %s", t, row.opcode, row.width,
                 row.height, row.x1, row.y1, (ok && test_errors == 0) ? "passed" : "failed");
    endtask

    //////////////////////////////
    // main sequence.
    //////////////////////////////
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cmd_byte = '0;
        cmd_valid = 1'b0;
        rd_addr = '0;
        pass_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        for (int a = 0; a < frame_bytes; a++) begin
            model[a] = '0;
        end
        void'($urandom(32'h7c75_03ac));
        build_table();

        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        test_errors = 0;
        check_flag("busy after reset", busy, 1'b0);
        check_flag("cmd_reject after reset", cmd_reject, 1'b0);
        if (test_errors == 0) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("reset state: %s", (test_errors == 0) ? "passed" : "failed");

        for (int t = 0; t < num_tests && !timed_out; t++) begin
            run_test(t);
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/frame_pkg.sv
hdl/fill_cmd_pkg.sv
hdl/fill_cmd_parser.sv
hdl/fill_area_engine.sv
hdl/write_queue.sv
hdl/frame_writer.sv
hdl/fill_subsystem_top.sv
tests/tb_fill_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fill subsystem testbench with Verilator.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_fill_subsystem -f verilog.f -o sim_fill > build.log 2>&1 &&
./obj_dir/sim_fill > sim.log 2>&1 ||
{ echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log &&
grep -q "^Simulation PASSED$" sim.log ||
{ echo "simulation did not pass"; exit 1; }
exit 0
